// ==== all.f ====
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu.sv
testbench/cpu_properties.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// ==== logic/cpu.sv ====
/*
 * Top level of the pipelined processor. Connects fetch, decode, execute
 * and memory stages. A host loads the program through the instruction
 * port while enable is low and reads results through the data port.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
   parameter int unsigned IMEM_ADDR_W = 9,
   parameter int unsigned DMEM_ADDR_W = 10
) (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 enable,
   input  wire cpu_pkg::word_t imem_addr,
   input  wire                 imem_wen,
   input  wire cpu_pkg::word_t imem_wdata,
   input  wire cpu_pkg::word_t dmem_addr,
   input  wire                 dmem_wen,
   input  wire                 dmem_ren,
   input  wire cpu_pkg::word_t dmem_wdata,
   output cpu_pkg::word_t      dmem_rdata
);

   cpu_pkg::word_t     if_instr;
   logic               stall;
   cpu_pkg::id_ex_t    id_ex;
   cpu_pkg::ex_mem_t   ex_mem;
   logic               wb_en;
   cpu_pkg::reg_addr_t wb_addr;
   cpu_pkg::word_t     wb_data;

   fetch_stage #(
      .IMEM_ADDR_W(IMEM_ADDR_W)
   ) fetch (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .stall     (stall),
      .imem_addr (imem_addr),
      .imem_wen  (imem_wen),
      .imem_wdata(imem_wdata),
      .if_instr  (if_instr)
   );

   // writeback port closes the loop back into the register file
   decode_stage decode (
      .clk     (clk),
      .reset   (reset),
      .enable  (enable),
      .if_instr(if_instr),
      .wb_en   (wb_en),
      .wb_addr (wb_addr),
      .wb_data (wb_data),
      .stall   (stall),
      .id_ex   (id_ex)
   );

   execute_stage execute (
      .clk    (clk),
      .reset  (reset),
      .enable (enable),
      .id_ex  (id_ex),
      .wb_en  (wb_en),
      .wb_addr(wb_addr),
      .wb_data(wb_data),
      .ex_mem (ex_mem)
   );

   memory_stage #(
      .DMEM_ADDR_W(DMEM_ADDR_W)
   ) memory (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .ex_mem    (ex_mem),
      .dmem_addr (dmem_addr),
      .dmem_wen  (dmem_wen),
      .dmem_ren  (dmem_ren),
      .dmem_wdata(dmem_wdata),
      .dmem_rdata(dmem_rdata),
      .wb_en     (wb_en),
      .wb_addr   (wb_addr),
      .wb_data   (wb_data)
   );

endmodule

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
/*
 * Shared types for the five-stage pipelined processor.
 * Holds the word and field widths, opcode and function codes, the ALU
 * operation enum and the pipeline register structs used by every stage.
 */
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;

   localparam opcode_t OP_RTYPE = 6'd0;
   localparam opcode_t OP_ADDI  = 6'd8;
   localparam opcode_t OP_LW    = 6'd35;
   localparam opcode_t OP_SW    = 6'd43;

   localparam funct_t FN_ADD = 6'd32;
   localparam funct_t FN_SUB = 6'd34;
   localparam funct_t FN_AND = 6'd36;
   localparam funct_t FN_OR  = 6'd37;
   localparam funct_t FN_SLT = 6'd42;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_t;

   // all zero means a no-op
   typedef struct packed {
      logic      reg_write;
      logic      mem_read;
      logic      mem_write;
      logic      mem_to_reg;
      logic      alu_src;
      alu_op_t   alu_op;
      reg_addr_t dest;
   } ctrl_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rs;
      reg_addr_t rt;
      word_t     rs_data;
      word_t     rt_data;
      word_t     imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t ctrl;
      word_t alu_result;
      word_t store_data;
   } ex_mem_t;

   typedef struct packed {
      logic      reg_write;
      logic      mem_to_reg;
      reg_addr_t dest;
      word_t     alu_result;
      word_t     load_data;
   } mem_wb_t;

endpackage

`default_nettype wire

// ==== logic/decode_stage.sv ====
/*
 * Decode stage: control decode, register read, load-use detection and
 * the ID/EX register. On a load-use hazard stall is raised for one cycle
 * and a bubble with zero control goes into execute.
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     enable,
   input  wire cpu_pkg::word_t     if_instr,
   input  wire                     wb_en,
   input  wire cpu_pkg::reg_addr_t wb_addr,
   input  wire cpu_pkg::word_t     wb_data,
   output logic                    stall,
   output cpu_pkg::id_ex_t         id_ex
);

   cpu_pkg::opcode_t   opcode;
   cpu_pkg::funct_t    funct;
   cpu_pkg::reg_addr_t rs;
   cpu_pkg::reg_addr_t rt;
   cpu_pkg::reg_addr_t rd;
   cpu_pkg::word_t     rs_data;
   cpu_pkg::word_t     rt_data;
   cpu_pkg::word_t     imm;
   cpu_pkg::ctrl_t     ctrl;

   assign opcode = if_instr[31:26];
   assign rs     = if_instr[25:21];
   assign rt     = if_instr[20:16];
   assign rd     = if_instr[15:11];
   assign funct  = if_instr[5:0];
   assign imm    = {{16{if_instr[15]}}, if_instr[15:0]};

   register_file regs (
      .clk    (clk),
      .reset  (reset),
      .raddr_1(rs),
      .raddr_2(rt),
      .wb_en  (wb_en & enable),
      .wb_addr(wb_addr),
      .wb_data(wb_data),
      .rdata_1(rs_data),
      .rdata_2(rt_data)
   );

   always_comb begin
      ctrl = '0;
      case (opcode)
         cpu_pkg::OP_RTYPE: begin
            ctrl.reg_write = 1'b1;
            ctrl.dest      = rd;
            case (funct)
               cpu_pkg::FN_ADD: ctrl.alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::FN_SUB: ctrl.alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::FN_AND: ctrl.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::FN_OR:  ctrl.alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::FN_SLT: ctrl.alu_op = cpu_pkg::ALU_SLT;
               default:         ctrl.reg_write = 1'b0;
            endcase
         end
         cpu_pkg::OP_ADDI: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
            ctrl.dest      = rt;
         end
         cpu_pkg::OP_LW: begin
            ctrl.reg_write  = 1'b1;
            ctrl.mem_read   = 1'b1;
            ctrl.mem_to_reg = 1'b1;
            ctrl.alu_src    = 1'b1;
            ctrl.dest       = rt;
         end
         cpu_pkg::OP_SW: begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
            ctrl.dest      = rt;
         end
         default: ctrl = '0;
      endcase
      // writes to r0 are dropped here so later stages never match it
      if (ctrl.dest == '0) begin
         ctrl.reg_write = 1'b0;
      end
   end

   assign stall = id_ex.ctrl.mem_read & id_ex.ctrl.reg_write &
                  ((id_ex.ctrl.dest == rs) | (id_ex.ctrl.dest == rt));

   always_ff @(posedge clk) begin
      if (reset) begin
         id_ex <= '0;
      end else if (enable) begin
         if (stall) begin
            id_ex.ctrl <= '0;
         end else begin
            id_ex.ctrl <= ctrl;
         end
         id_ex.rs      <= rs;
         id_ex.rt      <= rt;
         id_ex.rs_data <= rs_data;
         id_ex.rt_data <= rt_data;
         id_ex.imm     <= imm;
      end
   end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
/*
 * Execute stage: forwarding from EX/MEM and MEM/WB, operand selection,
 * the ALU and the EX/MEM register. The forwarded rt value is also the
 * store data handed to the memory stage.
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     enable,
   input  wire cpu_pkg::id_ex_t    id_ex,
   input  wire                     wb_en,
   input  wire cpu_pkg::reg_addr_t wb_addr,
   input  wire cpu_pkg::word_t     wb_data,
   output cpu_pkg::ex_mem_t        ex_mem
);

   cpu_pkg::word_t op_a;
   cpu_pkg::word_t fwd_rt;
   cpu_pkg::word_t op_b;
   cpu_pkg::word_t result;

   // a load in EX/MEM is never forwarded since the stall covers it
   function automatic cpu_pkg::word_t forward(input cpu_pkg::reg_addr_t src,
                                              input cpu_pkg::word_t reg_value);
      if (ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read && ex_mem.ctrl.dest == src) begin
         return ex_mem.alu_result;
      end else if (wb_en && wb_addr == src) begin
         return wb_data;
      end
      return reg_value;
   endfunction

   always_comb begin
      op_a   = forward(id_ex.rs, id_ex.rs_data);
      fwd_rt = forward(id_ex.rt, id_ex.rt_data);
      op_b   = id_ex.ctrl.alu_src ? id_ex.imm : fwd_rt;
   end

   always_comb begin
      case (id_ex.ctrl.alu_op)
         cpu_pkg::ALU_ADD: result = op_a + op_b;
         cpu_pkg::ALU_SUB: result = op_a - op_b;
         cpu_pkg::ALU_AND: result = op_a & op_b;
         cpu_pkg::ALU_OR:  result = op_a | op_b;
         cpu_pkg::ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
         default:          result = op_a + op_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem <= '0;
      end else if (enable) begin
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.alu_result <= result;
         ex_mem.store_data <= fwd_rt;
      end
   end

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
/*
 * Fetch stage: program counter, instruction memory and the IF/ID register.
 * The host writes program words through the external port at any time;
 * the pipeline reads the word at pc synchronously into if_instr.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
   parameter int unsigned IMEM_ADDR_W = 9
) (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 enable,
   input  wire                 stall,
   input  wire cpu_pkg::word_t imem_addr,
   input  wire                 imem_wen,
   input  wire cpu_pkg::word_t imem_wdata,
   output cpu_pkg::word_t      if_instr
);

   localparam int unsigned IMEM_WORDS = 2 ** IMEM_ADDR_W;

   cpu_pkg::word_t         imem [IMEM_WORDS];
   cpu_pkg::word_t         pc;
   logic [IMEM_ADDR_W-1:0] fetch_index;
   logic [IMEM_ADDR_W-1:0] host_index;
   logic                   advance;

   // byte addresses with the word index above the two low bits
   assign fetch_index = pc[IMEM_ADDR_W+1:2];
   assign host_index  = imem_addr[IMEM_ADDR_W+1:2];
   assign advance     = enable & ~stall;

   always_ff @(posedge clk) begin
      if (imem_wen) begin
         imem[host_index] <= imem_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc       <= '0;
         if_instr <= '0;
      end else if (advance) begin
         pc       <= pc + 32'd4;
         if_instr <= imem[fetch_index];
      end
   end

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
/*
 * Memory stage: dual-port data memory, the MEM/WB register and the
 * writeback select. The pipeline loads and stores at alu_result; the
 * host port writes at the edge and returns a read one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
   parameter int unsigned DMEM_ADDR_W = 10
) (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   enable,
   input  wire cpu_pkg::ex_mem_t ex_mem,
   input  wire cpu_pkg::word_t   dmem_addr,
   input  wire                   dmem_wen,
   input  wire                   dmem_ren,
   input  wire cpu_pkg::word_t   dmem_wdata,
   output cpu_pkg::word_t        dmem_rdata,
   output logic                  wb_en,
   output cpu_pkg::reg_addr_t    wb_addr,
   output cpu_pkg::word_t        wb_data
);

   localparam int unsigned DMEM_WORDS = 2 ** DMEM_ADDR_W;

   cpu_pkg::word_t         dmem [DMEM_WORDS];
   cpu_pkg::mem_wb_t       mem_wb;
   logic [DMEM_ADDR_W-1:0] pipe_index;
   logic [DMEM_ADDR_W-1:0] host_index;

   assign pipe_index = ex_mem.alu_result[DMEM_ADDR_W+1:2];
   assign host_index = dmem_addr[DMEM_ADDR_W+1:2];

   // host port runs regardless of enable and holds read data until the next read
   always_ff @(posedge clk) begin
      if (enable && ex_mem.ctrl.mem_write) begin
         dmem[pipe_index] <= ex_mem.store_data;
      end
      if (dmem_wen) begin
         dmem[host_index] <= dmem_wdata;
      end
      if (dmem_ren) begin
         dmem_rdata <= dmem[host_index];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wb <= '0;
      end else if (enable) begin
         mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
         mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
         mem_wb.dest       <= ex_mem.ctrl.dest;
         mem_wb.alu_result <= ex_mem.alu_result;
         mem_wb.load_data  <= dmem[pipe_index];
      end
   end

   assign wb_en   = mem_wb.reg_write;
   assign wb_addr = mem_wb.dest;
   assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
/*
 * Thirty-two entry register file with two combinational read ports and
 * one write port. A read of the register being written returns wb_data.
 */
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  wire                     clk,
   input  wire                     reset,
   input  wire cpu_pkg::reg_addr_t raddr_1,
   input  wire cpu_pkg::reg_addr_t raddr_2,
   input  wire                     wb_en,
   input  wire cpu_pkg::reg_addr_t wb_addr,
   input  wire cpu_pkg::word_t     wb_data,
   output cpu_pkg::word_t          rdata_1,
   output cpu_pkg::word_t          rdata_2
);

   cpu_pkg::word_t regs [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en && wb_addr != '0) begin
         regs[wb_addr] <= wb_data;
      end
   end

   // r0 reads zero, otherwise write-through before the array
   assign rdata_1 = (raddr_1 == '0) ? '0 :
                    (wb_en && wb_addr == raddr_1) ? wb_data : regs[raddr_1];
   assign rdata_2 = (raddr_2 == '0) ? '0 :
                    (wb_en && wb_addr == raddr_2) ? wb_data : regs[raddr_2];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator, the result comes from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module cpu_tb -o cpu_sim -f all.f \
   > build.log 2>&1 &&
   ./obj_dir/cpu_sim > sim.log 2>&1 ||
   { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/cpu_checker.sv ====
/*
 * Data-memory read checker. Latches the expected word when a host read is
 * issued and compares dmem_rdata once the read has returned.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
   input  wire                 clk,
   input  wire                 check_en,
   input  wire cpu_pkg::word_t check_word,
   input  wire cpu_pkg::word_t check_addr,
   input  wire cpu_pkg::word_t dmem_rdata,
   output int                  mismatches,
   output int                  checks_done
);

   logic           pending = 1'b0;
   cpu_pkg::word_t pending_word = '0;
   cpu_pkg::word_t pending_addr = '0;
   int             mismatch_count = 0;
   int             check_count = 0;

   assign mismatches  = mismatch_count;
   assign checks_done = check_count;

   // the read is issued at this edge and returns one cycle later
   always @(posedge clk) begin
      pending      <= check_en;
      pending_word <= check_word;
      pending_addr <= check_addr;
   end

   // compare between edges, where dmem_rdata is settled
   always @(negedge clk) begin
      if (pending) begin
         check_count <= check_count + 1;
         if (dmem_rdata !== pending_word) begin
            $display("Error at %0t ns: dmem_rdata at address %08h expected %08h actual %08h",
                     $time, pending_addr, pending_word, dmem_rdata);
            mismatch_count <= mismatch_count + 1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== testbench/cpu_golden.txt ====
# columns are kind, byte address and word, all in hex
# kind I is a program word, kind D is an expected data-memory word
I 00000000 20010007
I 00000004 2002FFFD
I 00000008 20030064
I 0000000C 00222020
I 00000010 00832822
I 00000014 00A33024
I 00000018 00C13825
I 0000001C 0041402A
I 00000020 0022482A
I 00000024 AC040000
I 00000028 AC050004
I 0000002C AC060008
I 00000030 AC07000C
I 00000034 AC080010
I 00000038 AC090014
I 0000003C 8C0A0004
I 00000040 01415820
I 00000044 AC0B0018
I 00000048 20000037
I 0000004C 00036020
I 00000050 AC0C001C
I 00000054 200D0001
I 00000058 AC0D03FC
D 00000000 00000004
D 00000004 FFFFFFA0
D 00000008 00000020
D 0000000C 00000027
D 00000010 00000001
D 00000014 00000000
D 00000018 FFFFFFA7
D 0000001C 00000064

// ==== testbench/cpu_properties.sv ====
/*
 * Concurrent assertions on the load-use stall and the reset state,
 * bound into the processor top level.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
   input wire                   clk,
   input wire                   reset,
   input wire                   enable,
   input wire                   stall,
   input wire cpu_pkg::id_ex_t  id_ex,
   input wire cpu_pkg::ex_mem_t ex_mem
);

   // one bubble is always enough for a load-use pair
   stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
      (enable && stall) |=> !(enable && stall))
      else $error("stall stayed high for two enabled cycles");

   bubble_after_stall: assert property (@(posedge clk) disable iff (reset)
      (enable && stall) |=> (id_ex.ctrl == '0))
      else $error("ID/EX control not cleared after a stall");

   no_write_after_reset: assert property (@(posedge clk)
      reset |=> !ex_mem.ctrl.mem_write)
      else $error("data memory write requested right after reset");

endmodule

bind cpu cpu_properties props (
   .clk   (clk),
   .reset (reset),
   .enable(enable),
   .stall (stall),
   .id_ex (id_ex),
   .ex_mem(ex_mem)
);

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
/*
 * Top-level testbench for the pipelined processor. Loads the program from
 * the golden file through the instruction port, runs until the program
 * stores its done word, then reads back data memory for cpu_checker.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

   localparam int IMEM_ADDR_W = 9;
   localparam int DMEM_ADDR_W = 10;
   localparam int IMEM_WORDS = 2 ** IMEM_ADDR_W;
   localparam int DMEM_WORDS = 2 ** DMEM_ADDR_W;
   localparam int POLL_LIMIT = 400;
   localparam cpu_pkg::word_t DONE_ADDR = 32'd1020;
   localparam string GOLDEN_PATH = "testbench/cpu_golden.txt";

   logic           clk;
   logic           reset;
   logic           enable;
   logic           imem_wen;
   logic           dmem_wen;
   logic           dmem_ren;
   cpu_pkg::word_t imem_addr;
   cpu_pkg::word_t imem_wdata;
   cpu_pkg::word_t dmem_addr;
   cpu_pkg::word_t dmem_wdata;
   cpu_pkg::word_t dmem_rdata;
   logic           check_en;
   cpu_pkg::word_t check_word;
   int             mismatches;
   int             checks_done;
   int             timeouts = 0;
   int             setup_errors = 0;
   integer         seed = 24366;
   cpu_pkg::word_t prog_addr[$];
   cpu_pkg::word_t prog_word[$];
   cpu_pkg::word_t exp_addr[$];
   cpu_pkg::word_t exp_word[$];

   cpu #(
      .IMEM_ADDR_W(IMEM_ADDR_W),
      .DMEM_ADDR_W(DMEM_ADDR_W)
   ) dut (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .imem_addr (imem_addr),
      .imem_wen  (imem_wen),
      .imem_wdata(imem_wdata),
      .dmem_addr (dmem_addr),
      .dmem_wen  (dmem_wen),
      .dmem_ren  (dmem_ren),
      .dmem_wdata(dmem_wdata),
      .dmem_rdata(dmem_rdata)
   );

   cpu_checker data_check (
      .clk        (clk),
      .check_en   (check_en),
      .check_word (check_word),
      .check_addr (dmem_addr),
      .dmem_rdata (dmem_rdata),
      .mismatches (mismatches),
      .checks_done(checks_done)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic read_golden();
      int             fd;
      int             fields;
      string          line;
      byte            kind;
      cpu_pkg::word_t addr;
      cpu_pkg::word_t word;
      fd = $fopen(GOLDEN_PATH, "r");
      if (fd == 0) begin
         $display("could not open the golden file %s", GOLDEN_PATH);
         setup_errors++;
         return;
      end
      while ($fgets(line, fd) > 0) begin
         fields = $sscanf(line, "%c %h %h", kind, addr, word);
         if (line[0] != "#" && fields == 3) begin
            if (kind == "I") begin
               prog_addr.push_back(addr);
               prog_word.push_back(word);
            end else if (kind == "D") begin
               exp_addr.push_back(addr);
               exp_word.push_back(word);
            end
         end
      end
      $fclose(fd);
      if (prog_word.size() == 0 || exp_word.size() == 0) begin
         $display("the golden file holds no program words or no expected words");
         setup_errors++;
      end
   endtask

   task automatic write_imem(input cpu_pkg::word_t addr, input cpu_pkg::word_t word);
      @(negedge clk);
      imem_addr  = addr;
      imem_wdata = word;
      imem_wen   = 1'b1;
   endtask

   task automatic write_dmem(input cpu_pkg::word_t addr, input cpu_pkg::word_t word);
      @(negedge clk);
      dmem_addr  = addr;
      dmem_wdata = word;
      dmem_wen   = 1'b1;
   endtask

   // unused imem words hold opcode 63, which decodes as a no-op
   task automatic load_memories();
      for (int i = 0; i < IMEM_WORDS; i++) begin
         write_imem(32'(i * 4), {6'h3F, 26'(i * 4)});
      end
      foreach (prog_addr[i]) begin
         write_imem(prog_addr[i], prog_word[i]);
      end
      for (int i = 0; i < DMEM_WORDS; i++) begin
         write_dmem(32'(i * 4), 32'hC0DE0000 ^ 32'(i * 4));
      end
      @(negedge clk);
      imem_wen = 1'b0;
      dmem_wen = 1'b0;
   endtask

   task automatic run_until_done();
      int   cycles;
      logic done;
      cycles = 0;
      done   = 1'b0;
      @(negedge clk);
      enable    = 1'b1;
      dmem_addr = DONE_ADDR;
      dmem_ren  = 1'b1;
      while (!done && cycles < POLL_LIMIT) begin
         @(negedge clk);
         cycles++;
         if (dmem_rdata === 32'd1) begin
            done = 1'b1;
         end
      end
      enable   = 1'b0;
      dmem_ren = 1'b0;
      if (!done) begin
         $display("timeout: the done word was not stored within %0d cycles", POLL_LIMIT);
         timeouts++;
      end
   endtask

   task automatic read_results();
      foreach (exp_addr[i]) begin
         @(negedge clk);
         dmem_addr  = exp_addr[i];
         dmem_ren   = 1'b1;
         check_en   = 1'b1;
         check_word = exp_word[i];
      end
      @(negedge clk);
      dmem_ren = 1'b0;
      check_en = 1'b0;
      @(negedge clk);
   endtask

   initial begin
      reset      = 1'b1;
      enable     = 1'b0;
      imem_addr  = '0;
      imem_wen   = 1'b0;
      imem_wdata = '0;
      dmem_addr  = '0;
      dmem_wen   = 1'b0;
      dmem_ren   = 1'b0;
      dmem_wdata = '0;
      check_en   = 1'b0;
      check_word = '0;
      read_golden();
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      load_memories();
      run_until_done();
      read_results();
      if (checks_done != exp_word.size()) begin
         $display("only %0d of %0d expected words were compared", checks_done,
                  exp_word.size());
         setup_errors++;
      end
      $display("error counts: %0d mismatches, %0d timeouts, %0d setup errors",
               mismatches, timeouts, setup_errors);
      if (mismatches == 0 && timeouts == 0 && setup_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
